// File: build.f
rtl/frontend_pkg.sv
rtl/fetch_requester.sv
rtl/prefetch_queue.sv
rtl/instr_aligner.sv
rtl/fetch_frontend.sv
bench/frontend_checker.sv
bench/frontend_asserts.sv
bench/frontend_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - rtl/frontend_pkg.sv
      - rtl/fetch_requester.sv
      - rtl/prefetch_queue.sv
      - rtl/instr_aligner.sv
      - rtl/fetch_frontend.sv
  - target: simulation
    files:
      - bench/frontend_checker.sv
      - bench/frontend_asserts.sv
      - bench/frontend_tb.sv

// File: bench/frontend_stim.txt
// Columns: kind _ field1 _ field2 _ field3. Kind 0 is an image word (addr, data, err flag),
// kind 1 a jump (consumed count, target, expected restart addr), kind 2 the end (count)
0_00000000_05134501_00000000
0_00000004_80820010_00000000
0_00000008_00b31141_00000000
0_0000000c_c60600c5_00000001
0_00000010_02934785_00000000
0_00000014_97820040_00000000
0_00000018_0637e022_00000000
0_0000001c_45010001_00000000
0_00000020_01138522_00000001
0_00000024_bfddff01_00000000
0_00000040_03934601_00000000
0_00000044_47050020_00000000
0_00000048_20839e3d_00000001
0_0000004c_87aa0041_00000000
1_00000009_00000042_00000040
1_0000000e_00000008_00000008
1_00000014_00000022_00000020
2_0000001e_00000000_00000000

// File: bench/frontend_tb.sv
// Testbench top for the fetch front end
// Clock and reset, stim loading, pipelined memory model,
// decode consumer with jump driver, watchdog and closing report

`timescale 1ns/10ps
`default_nettype none

module frontend_tb;
	import frontend_pkg::*;

	localparam logic [31:0] boot_addr = frontend_pkg::reset_vector;

	logic              clk;
	logic              rst_n;
	logic [31:0]       mem_addr;
	logic              mem_addr_vld;
	logic              mem_addr_rdy;
	logic [31:0]       mem_data;
	logic              mem_data_err;
	logic              mem_data_vld;
	jump_req_t         jump_target;
	logic              jump_target_vld;
	logic              jump_target_rdy;
	logic [31:0]       jump_expect;
	logic [31:0]       cir;
	logic [1:0]        cir_vld;
	logic [1:0]        cir_use;
	logic [1:0]        cir_err;

	// Memory window of 32 words, each stored as {err, data}
	logic [31:0][32:0] image;
	logic [99:0]       stim [64];
	int                jump_count [8];
	logic [31:0]       jump_tgt [8];
	logic [31:0]       jump_exp [8];
	int                n_jumps;
	int                n_entries;
	int                stop_count;
	logic              stim_loaded = 1'b0;
	int                addr_errors;
	int                stream_errors;
	int                flag_errors;
	int                hw_checked;

	fetch_frontend #(
		.reset_vector(boot_addr),
		.queue_depth(queue_depth)
	) i_fetch_frontend (
		.clk(clk),
		.rst_n(rst_n),
		.mem_addr(mem_addr),
		.mem_addr_vld(mem_addr_vld),
		.mem_addr_rdy(mem_addr_rdy),
		.mem_data(mem_data),
		.mem_data_err(mem_data_err),
		.mem_data_vld(mem_data_vld),
		.jump_target(jump_target),
		.jump_target_vld(jump_target_vld),
		.jump_target_rdy(jump_target_rdy),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_use(cir_use),
		.cir_err(cir_err)
	);

	frontend_checker #(
		.reset_vector(boot_addr)
	) i_frontend_checker (
		.clk(clk),
		.rst_n(rst_n),
		.mem_addr(mem_addr),
		.mem_addr_vld(mem_addr_vld),
		.mem_addr_rdy(mem_addr_rdy),
		.jump_target(jump_target),
		.jump_target_vld(jump_target_vld),
		.jump_target_rdy(jump_target_rdy),
		.jump_expect(jump_expect),
		.cir(cir),
		.cir_use(cir_use),
		.cir_err(cir_err),
		.image(image),
		.addr_errors(addr_errors),
		.stream_errors(stream_errors),
		.flag_errors(flag_errors),
		.hw_checked(hw_checked)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// Stim loading

	// Unlisted words get a fill that follows the full window address
	task automatic load_stim();
		logic [3:0]  kind;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		for (int i = 0; i < 32; i++) begin
			image[i] = {1'b0, 16'h1357 ^ 16'(i * 4), 16'h2468 ^ 16'(i * 4)};
		end
		for (int i = 0; i < 64; i++) begin
			stim[i] = '1;
		end
		$readmemh("bench/frontend_stim.txt", stim);
		n_jumps    = 0;
		n_entries  = 0;
		stop_count = 0;
		for (int i = 0; i < 64; i++) begin
			kind = stim[i][99:96];
			f1   = stim[i][95:64];
			f2   = stim[i][63:32];
			f3   = stim[i][31:0];
			if (kind <= 4'd2) begin
				n_entries++;
			end
			case (kind)
				4'd0: image[f1[6:2]] = {f3[0], f2};
				4'd1: begin
					jump_count[n_jumps] = f1;
					jump_tgt[n_jumps]   = f2;
					jump_exp[n_jumps]   = f3;
					n_jumps++;
				end
				4'd2: stop_count = f1;
				default: ;
			endcase
		end
		stim_loaded = 1'b1;
	endtask

	// --------------------------------------------------
	// Memory model

	// Accepted addresses are answered in order, 1 to 3 cycles later
	initial begin
		logic [31:0] ret_addr_q [$];
		int          ret_due_q [$];
		logic [31:0] addr;
		int          cycle;
		cycle        = 0;
		mem_addr_rdy = 1'b0;
		mem_data     = 32'h0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		forever begin
			@(posedge clk);
			cycle++;
			if (rst_n && mem_addr_vld && mem_addr_rdy) begin
				ret_addr_q.push_back(mem_addr);
				ret_due_q.push_back(cycle + 1 + int'($urandom % 3));
			end
			#1;
			mem_addr_rdy = ($urandom % 3) != 0;
			mem_data_vld = 1'b0;
			if (ret_due_q.size() != 0 && ret_due_q[0] <= cycle + 1) begin
				addr = ret_addr_q.pop_front();
				void'(ret_due_q.pop_front());
				mem_data     = image[addr[6:2]][31:0];
				mem_data_err = image[addr[6:2]][32];
				mem_data_vld = 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// Decode consumer and jump driver

	// Whole instructions only, a 32-bit one waits until both halves are in cir
	task automatic consume_instructions();
		int   consumed;
		int   jump_idx;
		logic jump_busy;
		consumed  = 0;
		jump_idx  = 0;
		jump_busy = 1'b0;
		while (consumed < stop_count || jump_busy) begin
			@(posedge clk);
			if (jump_target_vld && jump_target_rdy) begin
				jump_busy = 1'b0;
				jump_idx++;
			end
			#1;
			cir_use         = 2'd0;
			jump_target_vld = 1'b0;
			if (!jump_busy && jump_idx < n_jumps && consumed == jump_count[jump_idx]) begin
				jump_busy = 1'b1;
			end
			if (jump_busy) begin
				jump_target_vld    = 1'b1;
				jump_target.target = jump_tgt[jump_idx];
				jump_expect        = jump_exp[jump_idx];
			end else if (consumed < stop_count && cir_vld != 2'd0 && ($urandom % 4) != 0) begin
				if (cir[1:0] != 2'b11) begin
					cir_use = 2'd1;
				end else if (cir_vld == 2'd2) begin
					cir_use = 2'd2;
				end
				if (cir_use != 2'd0) begin
					consumed++;
				end
			end
		end
		@(posedge clk);
		#1;
		cir_use = 2'd0;
	endtask

	// --------------------------------------------------
	// Watchdog

	initial begin
		int limit;
		wait (stim_loaded);
		limit = (n_entries > 0 ? n_entries : 1) * 40;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int other_errors;
		int assert_errors;
		int total;
		void'($urandom(87655));
		other_errors    = 0;
		rst_n           = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		jump_expect     = 32'h0;
		cir_use         = 2'd0;
		load_stim();
		if (stop_count == 0) begin
			other_errors++;
			$display("The stim file has no end entry, so nothing would be consumed");
		end
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		consume_instructions();
		repeat (4) @(posedge clk);
		if (hw_checked == 0) begin
			other_errors++;
			$display("No halfword was consumed during the run");
		end
		assert_errors = i_fetch_frontend.i_frontend_asserts.fail_count;
		total = addr_errors + stream_errors + flag_errors + assert_errors + other_errors;
		$display("Errors: address %0d, stream %0d, flag %0d, assertion %0d, other %0d",
			addr_errors, stream_errors, flag_errors, assert_errors, other_errors);
		if (total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/frontend_asserts.sv
// Protocol assertions for the fetch front end, bound to the top level
// Address phase hold, outstanding fetch limit and cir_vld range

`timescale 1ns/10ps
`default_nettype none

module frontend_asserts (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] mem_addr,
	input logic        mem_addr_vld,
	input logic        mem_addr_rdy,
	input logic        mem_data_vld,
	input logic [1:0]  cir_vld
);
	// Failures seen so far, read by the testbench at the end of the run
	int fail_count = 0;

	logic [2:0] outstanding;

	// Accepted addresses whose data has not come back yet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outstanding <= 3'd0;
		end else begin
			outstanding <= outstanding + 3'(mem_addr_vld && mem_addr_rdy) - 3'(mem_data_vld);
		end
	end

	// --------------------------------------------------
	// Memory port

	// An address phase that is not accepted must stay exactly as it is
	a_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_addr_vld && !mem_addr_rdy |=> mem_addr_vld && $stable(mem_addr))
	else begin
		fail_count++;
		$error("mem_addr or mem_addr_vld changed before mem_addr_rdy");
	end

	a_outstanding: assert property (@(posedge clk) disable iff (!rst_n) outstanding <= 3'd2)
	else begin
		fail_count++;
		$error("more than two fetches are outstanding");
	end

	// --------------------------------------------------
	// Decode port

	a_cir_vld_range: assert property (@(posedge clk) disable iff (!rst_n) cir_vld <= 2'd2)
	else begin
		fail_count++;
		$error("cir_vld is larger than two halfwords");
	end

endmodule

bind fetch_frontend frontend_asserts i_frontend_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.mem_addr(mem_addr),
	.mem_addr_vld(mem_addr_vld),
	.mem_addr_rdy(mem_addr_rdy),
	.mem_data_vld(mem_data_vld),
	.cir_vld(cir_vld)
);

`default_nettype wire

// File: bench/frontend_checker.sv
// Scoreboard for the fetch front end
// Compares accepted fetch addresses with the sequential and jump targets,
// the jump ready flag with held address phases,
// and the consumed halfwords and error flags with the memory image

`timescale 1ns/10ps
`default_nettype none

module frontend_checker #(
	parameter logic [31:0] reset_vector = 32'h0000_0000
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [31:0]             mem_addr,
	input  logic                    mem_addr_vld,
	input  logic                    mem_addr_rdy,
	input  frontend_pkg::jump_req_t jump_target,
	input  logic                    jump_target_vld,
	input  logic                    jump_target_rdy,
	input  logic [31:0]             jump_expect,
	input  logic [31:0]             cir,
	input  logic [1:0]              cir_use,
	input  logic [1:0]              cir_err,
	input  logic [31:0][32:0]       image,
	output int                      addr_errors,
	output int                      stream_errors,
	output int                      flag_errors,
	output int                      hw_checked
);
	import frontend_pkg::*;

	logic [31:0] exp_addr;
	logic [31:0] exp_hw;
	logic        first_cycle;
	logic        first_accept;
	logic        after_jump;
	logic        addr_held;
	logic        jump_taken;
	int          jumps_seen;

	assign jump_taken = jump_target_vld && jump_target_rdy;

	// --------------------------------------------------
	// Fetch addresses

	// A jump redirects the expected address even when it is accepted in the same cycle
	task automatic compare_fetch_addr();
		logic [31:0] want;
		string       name;
		want = jump_taken ? jump_expect : exp_addr;
		if (first_accept) begin
			name = "reset";
		end else if (after_jump || jump_taken) begin
			name = "jump";
		end else begin
			name = "sequential_fetch";
		end
		if (mem_addr_vld && mem_addr_rdy) begin
			if (mem_addr !== want) begin
				addr_errors++;
				$display("** Error %s: expected addr %h, actual %h", name, want, mem_addr);
			end
			exp_addr     <= want + 32'd4;
			first_accept <= 1'b0;
			after_jump   <= 1'b0;
		end else begin
			exp_addr <= want;
			if (jump_taken) begin
				after_jump <= 1'b1;
			end
		end
	endtask

	// --------------------------------------------------
	// Consumed halfwords

	// Halfwords leave cir from the bottom, so halfword i sits at bits 16*i
	task automatic verify_consumed();
		logic [31:0] addr;
		logic [32:0] entry;
		logic [15:0] want;
		string       name;
		addr = exp_hw;
		name = (jumps_seen == 0) ? "assembly" : "jump";
		for (int i = 0; i < 2; i++) begin
			if (i < int'(cir_use)) begin
				// Image words are {err, data}, indexed by the word address in the window
				entry = image[addr[6:2]];
				want  = addr[1] ? entry[31:16] : entry[15:0];
				if (cir[w_hw*i +: w_hw] !== want) begin
					stream_errors++;
					$display("** Error %s: expected halfword %h at %h, actual %h",
						name, want, addr, cir[w_hw*i +: w_hw]);
				end
				if (cir_err[i] !== entry[32]) begin
					flag_errors++;
					$display("** Error bus_error: expected cir_err %b at %h, actual %b",
						entry[32], addr, cir_err[i]);
				end
				addr = addr + 32'd2;
				hw_checked++;
			end
		end
		// The stream restarts at the target halfword, so an odd target skips a half
		if (jump_taken) begin
			exp_hw     <= {jump_target.target[31:1], 1'b0};
			jumps_seen <= jumps_seen + 1;
		end else begin
			exp_hw <= addr;
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_addr      <= reset_vector;
			exp_hw        <= reset_vector;
			first_cycle   <= 1'b1;
			first_accept  <= 1'b1;
			after_jump    <= 1'b0;
			addr_held     <= 1'b0;
			jumps_seen    <= 0;
			addr_errors   = 0;
			stream_errors = 0;
			flag_errors   = 0;
			hw_checked    = 0;
		end else begin
			// The requester holds off for one cycle after reset
			if (first_cycle && mem_addr_vld) begin
				addr_errors++;
				$display("** Error reset: expected mem_addr_vld 0, actual 1");
			end
			first_cycle <= 1'b0;
			// Jumps may only be refused while an unaccepted address phase is held
			if (jump_target_rdy !== 1'b1 && !addr_held) begin
				addr_errors++;
				$display("** Error jump_ready: expected jump_target_rdy 1, actual %b",
					jump_target_rdy);
			end
			addr_held <= mem_addr_vld && !mem_addr_rdy;
			compare_fetch_addr();
			verify_consumed();
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_frontend.sv
// Top level of the instruction fetch front end
// Connects the fetch requester, prefetch queue and instruction aligner

`timescale 1ns/10ps
`default_nettype none

module fetch_frontend #(
	parameter logic [frontend_pkg::w_addr-1:0] reset_vector = frontend_pkg::reset_vector,
	parameter int                              queue_depth  = frontend_pkg::queue_depth
) (
	input  logic                            clk,
	input  logic                            rst_n,

	// Pipelined memory port, always word sized
	output logic [frontend_pkg::w_addr-1:0] mem_addr,
	output logic                            mem_addr_vld,
	input  logic                            mem_addr_rdy,
	input  logic [frontend_pkg::w_data-1:0] mem_data,
	input  logic                            mem_data_err,
	input  logic                            mem_data_vld,

	// Jump requests from the core
	input  frontend_pkg::jump_req_t         jump_target,
	input  logic                            jump_target_vld,
	output logic                            jump_target_rdy,

	// Decode port, counts are in halfwords
	output logic [31:0]                     cir,
	output logic [1:0]                      cir_vld,
	input  logic [1:0]                      cir_use,
	output logic [1:0]                      cir_err
);
	import frontend_pkg::*;

	fetch_word_t rx_word;
	fetch_word_t head;
	hw_vld_t     jump_hw_vld;
	logic        rx_vld;
	logic        jump_now;
	logic        q_empty;
	logic        q_full;
	logic        q_almost_full;
	logic        q_pop;
	logic        q_bypass;

	fetch_requester #(
		.reset_vector(reset_vector)
	) i_fetch_requester (
		.clk(clk),
		.rst_n(rst_n),
		.jump(jump_target),
		.jump_target_vld(jump_target_vld),
		.jump_target_rdy(jump_target_rdy),
		.mem_addr(mem_addr),
		.mem_addr_vld(mem_addr_vld),
		.mem_addr_rdy(mem_addr_rdy),
		.mem_data(mem_data),
		.mem_data_err(mem_data_err),
		.mem_data_vld(mem_data_vld),
		.q_full(q_full),
		.q_almost_full(q_almost_full),
		.jump_now(jump_now),
		.jump_hw_vld(jump_hw_vld),
		.rx_word(rx_word),
		.rx_vld(rx_vld)
	);

	prefetch_queue #(
		.queue_depth(queue_depth)
	) i_prefetch_queue (
		.clk(clk),
		.rst_n(rst_n),
		.jump_now(jump_now),
		.rx_word(rx_word),
		.rx_vld(rx_vld),
		.bypass(q_bypass),
		.pop(q_pop),
		.head(head),
		.empty(q_empty),
		.full(q_full),
		.almost_full(q_almost_full)
	);

	instr_aligner i_instr_aligner (
		.clk(clk),
		.rst_n(rst_n),
		.jump_now(jump_now),
		.jump_hw_vld(jump_hw_vld),
		.head(head),
		.empty(q_empty),
		.rx_word(rx_word),
		.rx_vld(rx_vld),
		.cir_use(cir_use),
		.pop(q_pop),
		.bypass(q_bypass),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_err(cir_err)
	);

endmodule

`default_nettype wire

// File: rtl/instr_aligner.sv
// Instruction assembly for decode
// Builds cir and the spare halfword buffer from queued or live words,
// applies decode consumption and keeps per-halfword bus errors

`timescale 1ns/10ps
`default_nettype none

module instr_aligner (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      jump_now,
	input  frontend_pkg::hw_vld_t     jump_hw_vld,
	input  frontend_pkg::fetch_word_t head,
	input  logic                      empty,
	input  frontend_pkg::fetch_word_t rx_word,
	input  logic                      rx_vld,
	input  logic [1:0]                cir_use,
	output logic                      pop,
	output logic                      bypass,
	output logic [31:0]               cir,
	output logic [1:0]                cir_vld,
	output logic [1:0]                cir_err
);
	import frontend_pkg::*;

	logic [1:0]        level;
	logic [w_hw-1:0]   hwbuf;
	logic [2:0]        hw_err;
	logic              first_pend;
	hw_vld_t           first_mask;
	fetch_word_t       src;
	logic              src_vld;
	hw_vld_t           src_hw;
	logic [2*w_hw-1:0] src_aligned;
	logic [3*w_hw-1:0] store_shifted;
	logic [3*w_hw-1:0] store_next;
	logic [2:0]        err_shifted;
	logic [2:0]        err_next;
	logic [1:0]        level_kept;
	logic [1:0]        level_next;
	logic [1:0]        fill;
	logic              room;

	// ------------------------------------------------
	// Source word selection

	// Oldest data wins, the bus is only used when the queue is empty
	assign src     = empty ? rx_word : head;
	assign src_vld = !empty || rx_vld;

	// The queue is flushed on a jump, so the next word taken is the jump word
	assign src_hw = first_pend ? (src.hw_vld & first_mask) : src.hw_vld;

	// Move a lone upper halfword down so it lines up like a lower one
	assign src_aligned = {src.data[2*w_hw-1:w_hw],
		src_hw[0] ? src.data[w_hw-1:0] : src.data[2*w_hw-1:w_hw]};

	// ------------------------------------------------
	// Consumption and refill

	// Halfwords left once decode has taken its share this cycle
	assign level_kept = level - cir_use;

	always_comb begin
		case (cir_use)
			2'd2:    store_shifted = {hwbuf, cir[2*w_hw-1:w_hw], hwbuf};
			2'd1:    store_shifted = {hwbuf, hwbuf, cir[2*w_hw-1:w_hw]};
			default: store_shifted = {hwbuf, cir};
		endcase
		case (cir_use)
			2'd2:    err_shifted = hw_err >> 2;
			2'd1:    err_shifted = hw_err >> 1;
			default: err_shifted = hw_err;
		endcase
	end

	// Three halfwords of storage, so a full word fits only with one left
	assign room   = level_kept <= ((&src_hw) ? 2'd1 : 2'd2);
	assign fill   = (room && src_vld) ? ((&src_hw) ? 2'd2 : 2'd1) : 2'd0;
	assign pop    = room && !empty;
	assign bypass = room && empty && rx_vld;

	// Fresh halfwords go in right above whatever decode left behind
	always_comb begin
		if (!room) begin
			store_next = store_shifted;
			err_next   = err_shifted;
		end else if (level_kept == 2'd2) begin
			store_next = {src_aligned[w_hw-1:0], store_shifted[2*w_hw-1:0]};
			err_next   = {src.err, err_shifted[1:0]};
		end else if (level_kept == 2'd1) begin
			store_next = {src_aligned, store_shifted[w_hw-1:0]};
			err_next   = {{2{src.err}}, err_shifted[0]};
		end else begin
			store_next = {store_shifted[3*w_hw-1:2*w_hw], src_aligned};
			err_next   = {err_shifted[2], {2{src.err}}};
		end
	end

	assign level_next = jump_now ? 2'd0 : level_kept + fill;

	// ------------------------------------------------
	// State

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= store_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level      <= 2'd0;
			cir_vld    <= 2'd0;
			hw_err     <= 3'b000;
			first_pend <= 1'b0;
			first_mask <= 2'b11;
		end else begin
			level   <= level_next;
			// Decode sees at most two halfwords, the third waits in hwbuf
			cir_vld <= (level_next == 2'd3) ? 2'd2 : level_next;
			hw_err  <= err_next;
			if (jump_now) begin
				first_pend <= 1'b1;
				first_mask <= jump_hw_vld;
			end else if (room && src_vld) begin
				first_pend <= 1'b0;
			end
		end
	end

	assign cir_err = hw_err[1:0];

endmodule

`default_nettype wire

// File: rtl/prefetch_queue.sv
// Prefetch queue between the bus and the instruction aligner
// Shifting queue of fetched words, entry 0 is the oldest,
// with per-halfword valid flags and error bits

`timescale 1ns/10ps
`default_nettype none

module prefetch_queue #(
	parameter int queue_depth = frontend_pkg::queue_depth
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      jump_now,
	input  frontend_pkg::fetch_word_t rx_word,
	input  logic                      rx_vld,
	input  logic                      bypass,
	input  logic                      pop,
	output frontend_pkg::fetch_word_t head,
	output logic                      empty,
	output logic                      full,
	output logic                      almost_full
);
	import frontend_pkg::*;

	logic [w_data-1:0]    q_data [queue_depth];
	logic                 q_err  [queue_depth];
	hw_vld_t              q_hw   [queue_depth];
	logic [queue_depth-1:0] q_vld;
	logic                 push;

	// A word that went straight into cir is not stored again
	assign push = rx_vld && !bypass;

	for (genvar i = 0; i < queue_depth; i++) begin : g_entry
		fetch_word_t src;
		logic        vld_above;
		logic        vld_below;

		assign q_vld[i] = |q_hw[i];

		// The top entry can only be filled from the bus
		if (i == queue_depth - 1) begin : g_top
			assign vld_above = 1'b0;
			assign src       = rx_word;
		end else begin : g_mid
			assign vld_above = q_vld[i+1];
			assign src       = q_vld[i+1] ? '{data: q_data[i+1], err: q_err[i+1],
				hw_vld: q_hw[i+1]} : rx_word;
		end

		// Entry 0 has nothing below it, so it always counts as backed
		if (i == 0) begin : g_bottom
			assign vld_below = 1'b1;
		end else begin : g_upper
			assign vld_below = q_vld[i-1];
		end

		// Data moves on every pop, and into the first free slot on a push
		always_ff @(posedge clk) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= src.data;
				q_err[i]  <= src.err;
			end
		end

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				q_hw[i] <= 2'b00;
			end else if (jump_now) begin
				q_hw[i] <= 2'b00;
			end else if (pop && (vld_above || q_vld[i])) begin
				// Topmost valid entry refills from the bus if a push comes with the pop
				q_hw[i] <= (vld_above || push) ? src.hw_vld : 2'b00;
			end else if (push && !pop && !q_vld[i] && vld_below) begin
				q_hw[i] <= src.hw_vld;
			end
		end
	end

	assign head        = '{data: q_data[0], err: q_err[0], hw_vld: q_hw[0]};
	assign empty       = !q_vld[0];
	assign full        = q_vld[queue_depth-1];
	assign almost_full = q_vld[queue_depth-2];

endmodule

`default_nettype wire

// File: rtl/fetch_requester.sv
// Fetch address generation for the front end
// Address phase control, in-flight and flush accounting,
// and filtering of returned bus words

`timescale 1ns/10ps
`default_nettype none

module fetch_requester #(
	parameter logic [frontend_pkg::w_addr-1:0] reset_vector = frontend_pkg::reset_vector
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  frontend_pkg::jump_req_t           jump,
	input  logic                              jump_target_vld,
	output logic                              jump_target_rdy,
	output logic [31:0]                       mem_addr,
	output logic                              mem_addr_vld,
	input  logic                              mem_addr_rdy,
	input  logic [frontend_pkg::w_data-1:0]   mem_data,
	input  logic                              mem_data_err,
	input  logic                              mem_data_vld,
	input  logic                              q_full,
	input  logic                              q_almost_full,
	output logic                              jump_now,
	output frontend_pkg::hw_vld_t             jump_hw_vld,
	output frontend_pkg::fetch_word_t         rx_word,
	output logic                              rx_vld
);
	import frontend_pkg::*;

	logic [w_addr-1:0] fetch_addr;
	logic [w_addr-1:0] jump_word;
	logic              addr_hold;
	logic              reset_holdoff;
	logic [1:0]        pending;
	logic [1:0]        flush_cnt;
	logic              issue;
	logic              accept;
	logic              fetch_stall;
	logic              addr_vld_raw;

	// ------------------------------------------------
	// Jump handshake

	// A held address phase must not change, so jumps wait for it
	assign jump_target_rdy = !addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;
	assign jump_word       = {jump.target[w_addr-1:2], 2'b00};

	// An odd-halfword target leaves only the upper half of its word useful
	assign jump_hw_vld = {1'b1, !jump.target[1]};

	// ------------------------------------------------
	// Address phase

	// Pending is registered, so one free queue entry is needed per fetch in flight
	assign fetch_stall = q_full || (q_almost_full && pending != 2'd0) || pending > 2'd1;

	always_comb begin
		mem_addr     = fetch_addr;
		addr_vld_raw = 1'b0;
		if (addr_hold) begin
			addr_vld_raw = 1'b1;
		end else if (jump_now) begin
			// The target goes out at once unless two fetches are already out
			mem_addr     = jump_word;
			addr_vld_raw = pending < 2'd2;
		end else if (!fetch_stall) begin
			addr_vld_raw = 1'b1;
		end
	end

	// Nothing is requested in the first cycle after reset
	assign mem_addr_vld = addr_vld_raw && !reset_holdoff;
	assign accept       = mem_addr_vld && mem_addr_rdy;

	// A request counts once, when it first appears on the port
	assign issue = mem_addr_vld && !addr_hold;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			addr_hold     <= 1'b0;
			fetch_addr    <= reset_vector;
		end else begin
			reset_holdoff <= 1'b0;
			addr_hold     <= mem_addr_vld && !mem_addr_rdy;
			// Fetch address runs ahead of decode in whole words
			if (jump_now) begin
				fetch_addr <= {jump.target[w_addr-1:2] + (w_addr - 2)'(accept), 2'b00};
			end else if (accept) begin
				fetch_addr <= fetch_addr + 32'd4;
			end
		end
	end

	// ------------------------------------------------
	// In-flight and flush accounting

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= 2'd0;
			flush_cnt <= 2'd0;
		end else begin
			pending <= pending + 2'(issue) - 2'(mem_data_vld);
			// Every fetch older than the jump must be thrown away on return
			if (jump_now) begin
				flush_cnt <= pending - 2'(mem_data_vld);
			end else if (flush_cnt != 2'd0 && mem_data_vld) begin
				flush_cnt <= flush_cnt - 2'd1;
			end
		end
	end

	// ------------------------------------------------
	// Returned data

	// Bus words are always whole, the aligner trims the first word after a jump
	assign rx_word = '{data: mem_data, err: mem_data_err, hw_vld: 2'b11};

	// Returns in the jump cycle itself belong to the old stream too
	assign rx_vld = mem_data_vld && flush_cnt == 2'd0 && !jump_now;

endmodule

`default_nettype wire

// File: rtl/frontend_pkg.sv
// Shared definitions for the instruction fetch front end
// Bus and halfword widths, prefetch queue depth and boot address
// Packed structs for fetched words and jump requests

`default_nettype none

package frontend_pkg;

	// ------------------------------------------------
	// Widths and sizes

	// Fetch address and returned word widths
	parameter int w_addr = 32;
	parameter int w_data = 32;

	// Decode works in halfwords because of the C extension
	parameter int w_hw = 16;

	// Two entries are enough to absorb both in-flight fetches under a stall
	parameter int queue_depth = 2;

	// Address of the first fetch after reset
	parameter logic [w_addr-1:0] reset_vector = 32'h0000_0000;

	// ------------------------------------------------
	// Types

	// One bit per halfword of a fetched word, bit 0 is the lower halfword
	typedef logic [1:0] hw_vld_t;

	// A returned bus word with its error flag and halfword mask (35 bits)
	typedef struct packed {
		logic [w_data-1:0] data;
		logic              err;
		hw_vld_t           hw_vld;
	} fetch_word_t;

	// Halfword-aligned target of a jump
	typedef struct packed {
		logic [w_addr-1:0] target;
	} jump_req_t;

endpackage

`default_nettype wire
